// File: Bender.yml
package:
  name: mspi

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mspi_pkg.sv
      - hw/spi_bitsync.sv
      - hw/spi_buf_ram.sv
      - hw/mspi_avmm_csr.sv
      - hw/mspi_engine.sv
      - hw/mspi_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/mspi_tb.sv

// File: dv/mspi_tb.sv
// Testbench for the memory-mapped SPI master, top mspi_top as UUT.
// Runs a CSR table over the avmm bus, then loopback transfers of 1, 4 and 16 words
// with mosi tied to miso, checking rx data, completion interrupt and sck framing.
`timescale 1ns/100ps
`include "mspi_macros.svh"

module mspi_tb;

   import mspi_pkg::*;

   localparam int AVMM_NS   = 8;    // avmm_clk period
   localparam int SCLK_NS   = 10;   // sclk period
   localparam int TABLE_LEN = 16;
   localparam int N_XFER    = 3;
   localparam int XFER_WORDS [N_XFER] = '{1, 4, 16};
   // spare cmd bits per transfer, must survive the go clear
   localparam mspi_word_t XFER_EXTRA [N_XFER] = '{32'h5a5a_00a4, 32'hc3c3_007e, 32'h0f0f_0010};

   typedef enum logic {op_wr, op_rd} bus_op_e;

   typedef struct packed {
      bus_op_e     op;
      logic [12:0] addr;
      mspi_word_t  data;       // write data
      mspi_word_t  exp_data;   // read expectation
   } bus_step_t;

   ////////////////////////////////////////////////////////////
   // csr table, go bit always clear
   ////////////////////////////////////////////////////////////
   bus_step_t steps [TABLE_LEN] = '{
      '{op_wr, `MSPI_ADDR_CMD,          32'h1234_5678, 32'h0},
      '{op_rd, `MSPI_ADDR_CMD,          32'h0,         32'h1234_5678},
      '{op_wr, `MSPI_ADDR_CMD,          32'hfedc_ba98, 32'h0},
      '{op_rd, `MSPI_ADDR_CMD,          32'h0,         32'hfedc_ba98},
      '{op_wr, `MSPI_ADDR_CMD,          32'hffff_fffe, 32'h0},
      '{op_rd, `MSPI_ADDR_CMD,          32'h0,         32'hffff_fffe},
      '{op_rd, 13'h004,                 32'h0,         32'h0},          // hole
      '{op_rd, 13'h008,                 32'h0,         32'h0},
      '{op_rd, 13'h0800,                32'h0,         32'h0},
      '{op_wr, `MSPI_TX_BASE,           32'hdead_beef, 32'h0},
      '{op_rd, `MSPI_TX_BASE,           32'h0,         32'h0},          // tx is write only
      '{op_rd, `MSPI_TX_BASE + 13'h3fc, 32'h0,         32'h0},
      '{op_rd, 13'h1400,                32'h0,         32'h0},          // just past rx
      '{op_rd, 13'h1ffc,                32'h0,         32'h0},
      '{op_wr, `MSPI_ADDR_CMD,          32'h0,         32'h0},
      '{op_rd, `MSPI_ADDR_CMD,          32'h0,         32'h0}
   };

   logic        avmm_clk, avmm_rst_n, sclk;
   logic [12:0] address;
   logic        read, write;
   logic [3:0]  byteenable;
   mspi_word_t  writedata, readdata;
   logic        readdatavalid, spi_inta;
   logic        spi_sck, spi_cs_n, spi_mosi;
   wire         spi_miso;

   int          check_errors = 0;
   int          test_pass = 0;
   int          test_fail = 0;
   int          sck_count = 0;   // sck rises inside the frame
   bit          mon_on = 1'b0;
   logic [31:0] rng_state = 32'h6f01_8135;
   mspi_word_t  tx_words [`MSPI_BUF_SIZE];   // what rx must return
   mspi_word_t  mosi_word = '0;   // mosi bits at sck rise, msb first

   assign spi_miso = spi_mosi;   // loopback

   mspi_top UUT (
      .avmm_clk      (avmm_clk),
      .avmm_rst_n    (avmm_rst_n),
      .address       (address),
      .read          (read),
      .write         (write),
      .byteenable    (byteenable),
      .writedata     (writedata),
      .readdata      (readdata),
      .readdatavalid (readdatavalid),
      .spi_inta      (spi_inta),
      .sclk          (sclk),
      .spi_sck       (spi_sck),
      .spi_cs_n      (spi_cs_n),
      .spi_mosi      (spi_mosi),
      .spi_miso      (spi_miso)
   );

   always #(AVMM_NS / 2) avmm_clk = ~avmm_clk;
   always #(SCLK_NS / 2) sclk = ~sclk;

   // xorshift32
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // reset + every transfer + table, doubled
   function automatic int watchdog_ns();
      int total;
      total = 10 * AVMM_NS;
      for (int k = 0; k < N_XFER; k++)
         total += (XFER_WORDS[k] * 66 + 20) * SCLK_NS;
      total += TABLE_LEN * 4 * AVMM_NS;
      return 2 * total;
   endfunction

   task automatic compare_word(input string name, input mspi_word_t exp, input mspi_word_t act);
      assert (act === exp)
      else begin
         $display("ERROR %s expected %h got %h", name, exp, act);
         check_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // avmm bus, drive 1 ns after the rising edge
   ////////////////////////////////////////////////////////////
   task automatic bus_write(input logic [12:0] addr, input mspi_word_t data);
      @(posedge avmm_clk);
      #1;
      address   = addr;
      writedata = data;
      write     = 1'b1;
      @(posedge avmm_clk);
      #1;
      write = 1'b0;   // one cycle pulse
   endtask

   // read held two cycles, valid expected only after the second edge
   task automatic bus_read(input logic [12:0] addr, output mspi_word_t data);
      int pulses;
      int pulse_cyc;
      pulses    = 0;
      pulse_cyc = 0;
      data      = 'x;
      @(posedge avmm_clk);
      #1;
      address = addr;
      read    = 1'b1;
      for (int c = 1; c <= 4; c++) begin
         @(posedge avmm_clk);
         #1;
         if (c == 2) read = 1'b0;
         if (readdatavalid === 1'b1) begin
            pulses++;
            pulse_cyc = c;
            data      = readdata;
         end
      end
      assert (pulses == 1 && pulse_cyc == 2)
      else begin
         $display("read of address %h got %0d readdatavalid pulses, last in cycle %0d",
                  addr, pulses, pulse_cyc);
         check_errors++;
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      if (check_errors == err_before) begin
         test_pass++;
         $display("test %s: pass", name);
      end
      else begin
         test_fail++;
         $display("test %s: fail, %0d errors", name, check_errors - err_before);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // one loopback transfer with its completion checks
   ////////////////////////////////////////////////////////////
   task automatic run_transfer(input int k);
      int         n;
      int         err_before;
      int         tries;
      int         wait_cycles;
      int         limit;
      bit         busy_seen;
      mspi_word_t cmd_val;
      mspi_word_t rd;
      n          = XFER_WORDS[k];
      err_before = check_errors;
      for (int i = 0; i < n; i++) begin
         tx_words[i] = next_random();
         bus_write(`MSPI_TX_BASE + 13'(4 * i), tx_words[i]);
      end
      cmd_val   = (XFER_EXTRA[k] & 32'hffff_00fe) | (32'(n - 1) << 8) | 32'h1;
      sck_count = 0;
      bus_write(`MSPI_ADDR_CMD, cmd_val);

      // busy comes back through two synchronizers
      tries     = 0;
      busy_seen = 1'b0;
      while (!busy_seen && tries < 16) begin
         bus_read(`MSPI_ADDR_STATUS, rd);
         busy_seen = (rd[0] === 1'b1);
         tries++;
      end
      assert (busy_seen)
      else begin
         $display("status never showed busy after go was written");
         check_errors++;
      end
      compare_word("spi_inta", 32'h0, {31'h0, spi_inta});   // dropped by the new start
      bus_read(`MSPI_ADDR_STATUS, rd);
      compare_word("readdata (status busy)", 32'h1, rd);

      limit       = 2 * n * 66 * SCLK_NS / AVMM_NS + 64;
      wait_cycles = 0;
      while (spi_inta !== 1'b1 && wait_cycles < limit) begin
         @(posedge avmm_clk);
         #1;
         wait_cycles++;
      end
      assert (spi_inta === 1'b1)
      else begin
         $display("spi_inta did not rise within %0d cycles of the transfer start", limit);
         check_errors++;
      end

      compare_word("spi_cs_n", 32'h1, {31'h0, spi_cs_n});
      compare_word("spi_sck rising edges", 32'(32 * n), 32'(sck_count));
      bus_read(`MSPI_ADDR_STATUS, rd);
      compare_word("readdata (status done)", 32'h2, rd);
      bus_read(`MSPI_ADDR_CMD, rd);
      compare_word("readdata (cmd after done)", cmd_val & ~32'h1, rd);   // go cleared only
      for (int i = 0; i < n; i++) begin
         bus_read(`MSPI_RX_BASE + 13'(4 * i), rd);
         compare_word($sformatf("readdata (rx word %0d)", i), tx_words[i], rd);
      end
      finish_test($sformatf("transfer_%0d_words", n), err_before);
   endtask

   ////////////////////////////////////////////////////////////
   // serial side monitors
   ////////////////////////////////////////////////////////////
   // mosi is steady at the sck rise, it only moves after the fall
   always @(posedge spi_sck) begin
      if (spi_cs_n === 1'b0) begin
         sck_count = sck_count + 1;
         mosi_word = {mosi_word[30:0], spi_mosi};
         if (sck_count % 32 == 0)
            compare_word($sformatf("spi_mosi (word %0d)", sck_count / 32 - 1),
                         tx_words[sck_count / 32 - 1], mosi_word);
      end
   end

   // outputs move on posedge sclk, look at the middle
   always @(negedge sclk) begin
      if (mon_on) begin
         assert (!(spi_cs_n === 1'b1 && spi_sck !== 1'b0))
         else begin
            $display("spi_sck was not low while spi_cs_n was high");
            check_errors++;
         end
      end
   end

   initial begin
      #(watchdog_ns());
      $display("watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      int         err_before;
      mspi_word_t rd;
      avmm_clk   = 1'b0;
      sclk       = 1'b0;
      avmm_rst_n = 1'b0;
      address    = '0;
      read       = 1'b0;
      write      = 1'b0;
      byteenable = 4'hf;   // full words
      writedata  = '0;
      repeat (10) @(posedge avmm_clk);
      #1;
      avmm_rst_n = 1'b1;
      mon_on     = 1'b1;

      // reset values
      err_before = check_errors;
      compare_word("readdatavalid", 32'h0, {31'h0, readdatavalid});
      compare_word("spi_inta", 32'h0, {31'h0, spi_inta});
      compare_word("spi_sck", 32'h0, {31'h0, spi_sck});
      compare_word("spi_cs_n", 32'h1, {31'h0, spi_cs_n});
      bus_read(`MSPI_ADDR_CMD, rd);
      compare_word("readdata (cmd)", 32'h0, rd);
      bus_read(`MSPI_ADDR_STATUS, rd);
      compare_word("readdata (status)", 32'h0, rd);
      finish_test("reset_state", err_before);

      err_before = check_errors;
      for (int s = 0; s < TABLE_LEN; s++) begin
         if (steps[s].op == op_wr) begin
            bus_write(steps[s].addr, steps[s].data);
         end
         else begin
            bus_read(steps[s].addr, rd);
            compare_word($sformatf("readdata at %h", steps[s].addr), steps[s].exp_data, rd);
         end
      end
      finish_test("csr_table", err_before);

      for (int k = 0; k < N_XFER; k++) run_transfer(k);

      $display("tests passed %0d, tests failed %0d, check errors %0d",
               test_pass, test_fail, check_errors);
      if (test_fail == 0 && check_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: hw/mspi_avmm_csr.sv
// Host side of the SPI master, all in avmm_clk.
// Decodes the avmm windows, holds cmd and status, delays reads by two cycles,
// raises spi_inta at end of transfer and owns both dual-clock buffers.
`timescale 1ns/100ps
`include "mspi_macros.svh"

module mspi_avmm_csr #(
   parameter int BUF_SIZE = `MSPI_BUF_SIZE
) (
   input  logic                          avmm_clk,
   input  logic                          avmm_rst_n,
   input  logic [12:0]                   address,      // byte address
   input  logic                          read,
   input  logic                          write,
   input  logic [3:0]                    byteenable,   // ignored, full words only
   input  mspi_pkg::mspi_word_t          writedata,
   output mspi_pkg::mspi_word_t          readdata,
   output logic                          readdatavalid,
   output logic                          spi_inta,
   output mspi_pkg::mspi_cmd_t           cmd_reg,      // to engine
   input  logic                          sclk,
   input  logic                          spi_active,   // sclk domain
   input  logic [$clog2(BUF_SIZE)-1:0]   tx_buf_raddr,
   output mspi_pkg::mspi_word_t          tx_buf_rdata,
   input  logic                          rx_buf_we,
   input  logic [$clog2(BUF_SIZE)-1:0]   rx_buf_waddr,
   input  mspi_pkg::mspi_word_t          rx_buf_wdata
);

   import mspi_pkg::*;

   localparam int BUF_AW = $clog2(BUF_SIZE);

   // window bounds, byte addresses
   localparam logic [12:0] ADDR_CMD    = `MSPI_ADDR_CMD;
   localparam logic [12:0] ADDR_STATUS = `MSPI_ADDR_STATUS;
   localparam logic [12:0] TX_BASE     = `MSPI_TX_BASE;
   localparam logic [12:0] TX_END      = `MSPI_TX_BASE + 13'(4 * BUF_SIZE);
   localparam logic [12:0] RX_BASE     = `MSPI_RX_BASE;
   localparam logic [12:0] RX_END      = `MSPI_RX_BASE + 13'(4 * BUF_SIZE);

   logic              sel_cmd, sel_status, sel_tx, sel_rx;
   logic              we_cmd;
   logic [12:0]       tx_off, rx_off;     // byte offset into window
   logic              busy_aclk, busy_d1; // synced spi_active
   logic              busy_fall, busy_rise;
   logic [1:0]        read_dly;           // read strobe history
   mspi_word_t        status_reg;
   mspi_word_t        rdata_comb;
   mspi_word_t        rx_buf_rdata;
   logic              tx_buf_we;
   logic [BUF_AW-1:0] tx_buf_waddr;
   mspi_word_t        tx_buf_wdata;

   ////////////////////////////////////////////////////////////
   // address decode
   ////////////////////////////////////////////////////////////
   assign sel_cmd    = (address == ADDR_CMD);
   assign sel_status = (address == ADDR_STATUS);
   assign sel_tx     = (address >= TX_BASE) && (address < TX_END);
   assign sel_rx     = (address >= RX_BASE) && (address < RX_END);
   assign we_cmd     = write & sel_cmd;

   assign tx_off = address - TX_BASE;
   assign rx_off = address - RX_BASE;

   // busy from the shift side
   spi_bitsync u_busy_sync (
      .clk      (avmm_clk),
      .rst_n    (avmm_rst_n),
      .data_in  (spi_active),
      .data_out (busy_aclk)
   );

   assign busy_fall = ~busy_aclk & busy_d1;   // transfer done
   assign busy_rise = busy_aclk & ~busy_d1;   // transfer started

   assign status_reg = {30'h0, spi_inta, busy_aclk};

   ////////////////////////////////////////////////////////////
   // control registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge avmm_clk) begin
      if (!avmm_rst_n) begin
         cmd_reg       <= '0;
         busy_d1       <= 1'b0;
         read_dly      <= 2'b00;
         readdatavalid <= 1'b0;
         spi_inta      <= 1'b0;
         tx_buf_we     <= 1'b0;
      end
      else begin
         if (we_cmd)
            cmd_reg <= mspi_cmd_t'(writedata);
         else if (busy_fall)
            cmd_reg.go <= 1'b0;   // other fields kept

         if (busy_fall)      spi_inta <= 1'b1;
         else if (busy_rise) spi_inta <= 1'b0;   // next go clears it

         busy_d1 <= busy_aclk;

         // valid on the second edge after read rises, one cycle wide
         read_dly      <= {read_dly[0], read};
         readdatavalid <= read_dly[0] & ~read_dly[1];

         tx_buf_we <= write & sel_tx;
      end
   end

   // payload side of the pipelines
   always_ff @(posedge avmm_clk) begin
      readdata     <= rdata_comb;
      tx_buf_waddr <= tx_off[BUF_AW+1:2];   // byte to word
      tx_buf_wdata <= writedata;
   end

   // read mux, tx window and holes give zero
   always_comb begin
      rdata_comb = '0;
      if (sel_cmd)         rdata_comb = cmd_reg;
      else if (sel_status) rdata_comb = status_reg;
      else if (sel_rx)     rdata_comb = rx_buf_rdata;  // ram read from previous edge
   end

   ////////////////////////////////////////////////////////////
   // buffers
   ////////////////////////////////////////////////////////////
   spi_buf_ram #(
      .DEPTH (BUF_SIZE)
   ) u_tx_buf (
      .wr_clk  (avmm_clk),
      .wr_en   (tx_buf_we),
      .wr_addr (tx_buf_waddr),
      .wr_data (tx_buf_wdata),
      .rd_clk  (sclk),
      .rd_addr (tx_buf_raddr),
      .rd_data (tx_buf_rdata)
   );

   spi_buf_ram #(
      .DEPTH (BUF_SIZE)
   ) u_rx_buf (
      .wr_clk  (sclk),
      .wr_en   (rx_buf_we),
      .wr_addr (rx_buf_waddr),
      .wr_data (rx_buf_wdata),
      .rd_clk  (avmm_clk),
      .rd_addr (rx_off[BUF_AW+1:2]),   // address held over both read cycles
      .rd_data (rx_buf_rdata)
   );

   // one pulse per read, host drops read between accesses
   a_rdv_single : assert property (@(posedge avmm_clk) disable iff (!avmm_rst_n)
      readdatavalid |=> !readdatavalid);

   // cmd must stay put while the engine runs
   a_cmd_idle : assert property (@(posedge avmm_clk) disable iff (!avmm_rst_n)
      we_cmd |-> !busy_aclk);

endmodule

// File: hw/mspi_engine.sv
// Shift side of the SPI master, all in sclk.
// On a rising go it walks tx words 0..last_word out MSB-first in mode 0
// and writes each received word into the rx buffer at the same index.
`timescale 1ns/100ps
`include "mspi_macros.svh"

module mspi_engine #(
   parameter int BUF_SIZE = `MSPI_BUF_SIZE
) (
   input  logic                        sclk,
   input  logic                        rst_n,         // already synced to sclk
   input  mspi_pkg::mspi_cmd_t         cmd_reg,       // avmm domain
   output logic [$clog2(BUF_SIZE)-1:0] tx_buf_raddr,
   input  mspi_pkg::mspi_word_t        tx_buf_rdata,
   output logic                        rx_buf_we,
   output logic [$clog2(BUF_SIZE)-1:0] rx_buf_waddr,
   output mspi_pkg::mspi_word_t        rx_buf_wdata,
   output logic                        spi_active,
   output logic                        spi_sck,
   output logic                        spi_cs_n,
   output logic                        spi_mosi,
   input  logic                        spi_miso
);

   import mspi_pkg::*;

   localparam int BUF_AW = $clog2(BUF_SIZE);

   mspi_state_e       state;
   logic              go_sclk, go_d1, go_rise;
   logic [BUF_AW-1:0] word_idx;   // word being shifted
   logic [BUF_AW-1:0] last_idx;   // sampled at start
   logic [5:0]        bit_cnt;    // two counts per sck period
   mspi_word_t        shreg;      // tx out at top, rx in at bottom
   logic              miso_q;     // bit taken at sck rise

   spi_bitsync u_go_sync (
      .clk      (sclk),
      .rst_n    (rst_n),
      .data_in  (cmd_reg.go),
      .data_out (go_sclk)
   );

   assign go_rise = go_sclk & ~go_d1;

   ////////////////////////////////////////////////////////////
   // transfer fsm
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sclk) begin
      if (!rst_n) begin
         state        <= st_idle;
         go_d1        <= 1'b0;
         word_idx     <= '0;
         last_idx     <= '0;
         tx_buf_raddr <= '0;     // ram shows word 0 while idle
         bit_cnt      <= '0;
         spi_active   <= 1'b0;
         spi_sck      <= 1'b0;
         spi_cs_n     <= 1'b1;
      end
      else begin
         go_d1 <= go_sclk;
         case (state)
            st_idle: begin
               if (go_rise) begin
                  state      <= st_load;
                  word_idx   <= '0;
                  last_idx   <= BUF_AW'(cmd_reg.last_word);  // stable while go set
                  spi_active <= 1'b1;
                  spi_cs_n   <= 1'b0;
               end
            end
            st_load: begin
               state   <= st_shift;
               bit_cnt <= '0;
               // prefetch next word, it has the whole shift time to arrive
               if (word_idx != last_idx) tx_buf_raddr <= word_idx + 1'b1;
            end
            st_shift: begin
               spi_sck <= ~bit_cnt[0];            // rise on even, fall on odd
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 6'd63) state <= st_store;  // last fall
            end
            st_store: begin
               if (word_idx == last_idx) begin
                  state        <= st_idle;
                  spi_active   <= 1'b0;    // drops with the last rx write
                  spi_cs_n     <= 1'b1;
                  tx_buf_raddr <= '0;
               end
               else begin
                  state    <= st_load;
                  word_idx <= word_idx + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // shift datapath
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sclk) begin
      if (state == st_load)
         shreg <= tx_buf_rdata;
      else if (state == st_shift && bit_cnt[0])
         shreg <= {shreg[30:0], miso_q};   // mosi moves after sck fall

      if (state == st_shift && !bit_cnt[0])
         miso_q <= spi_miso;               // sample at sck rise
   end

   assign spi_mosi = shreg[31] & ~spi_cs_n;   // quiet low between transfers

   // rx write happens in the store cycle
   assign rx_buf_we    = (state == st_store);
   assign rx_buf_waddr = word_idx;
   assign rx_buf_wdata = shreg;

   // never fetch past the count the host gave
   a_raddr_bound : assert property (@(posedge sclk) disable iff (!rst_n)
      spi_active |-> (tx_buf_raddr <= last_idx));

   // mode 0, clock parked low outside the frame
   a_sck_idle : assert property (@(posedge sclk) disable iff (!rst_n)
      spi_cs_n |-> !spi_sck);

endmodule

// File: hw/mspi_macros.svh
// Buffer depth and CSR byte addresses of the SPI master.
// Included by the RTL and the testbench wherever a size or an address is needed.
`ifndef MSPI_MACROS_SVH
`define MSPI_MACROS_SVH

// words per buffer, same for tx and rx
`define MSPI_BUF_SIZE      256

////////////////////////////////////////////////////////////
// csr byte addresses on the 13-bit avmm address
////////////////////////////////////////////////////////////
`define MSPI_ADDR_CMD      13'h000   // go, last_word
`define MSPI_ADDR_STATUS   13'h00c   // busy, inta

// buffer windows
`define MSPI_TX_BASE       13'h200   // write only
`define MSPI_RX_BASE       13'h1000  // read only

`endif

// File: hw/mspi_pkg.sv
// Types shared by the SPI master blocks.
// Import where a word, the command layout or the engine state is needed.
package mspi_pkg;

   // one buffer / bus word
   typedef logic [31:0] mspi_word_t;

   // command register layout
   typedef struct packed {
      logic [15:0] rsvd_hi;    // stored, no function
      logic [7:0]  last_word;  // word count minus one
      logic [6:0]  rsvd_lo;    // stored, no function
      logic        go;         // start, cleared at end of transfer
   } mspi_cmd_t;

   // shift engine states
   typedef enum logic [1:0] {
      st_idle,
      st_load,   // tx word into shift reg
      st_shift,  // 32 sck periods
      st_store   // rx word into buffer
   } mspi_state_e;

endpackage

// File: hw/mspi_top.sv
// Top of the memory-mapped SPI master.
// Host bus on avmm_clk, serial side on sclk, buffers cross between them.
`timescale 1ns/100ps
`include "mspi_macros.svh"

module mspi_top (
   // avmm host side
   input  logic                 avmm_clk,
   input  logic                 avmm_rst_n,
   input  logic [12:0]          address,
   input  logic                 read,
   input  logic                 write,
   input  logic [3:0]           byteenable,
   input  mspi_pkg::mspi_word_t writedata,
   output mspi_pkg::mspi_word_t readdata,
   output logic                 readdatavalid,
   output logic                 spi_inta,
   // spi side
   input  logic                 sclk,
   output logic                 spi_sck,
   output logic                 spi_cs_n,
   output logic                 spi_mosi,
   input  logic                 spi_miso
);

   import mspi_pkg::*;

   localparam int BUF_AW = $clog2(`MSPI_BUF_SIZE);

   logic              sclk_rst_n;   // avmm reset seen in sclk
   mspi_cmd_t         cmd_reg;
   logic              spi_active;
   logic [BUF_AW-1:0] tx_buf_raddr;
   mspi_word_t        tx_buf_rdata;
   logic              rx_buf_we;
   logic [BUF_AW-1:0] rx_buf_waddr;
   mspi_word_t        rx_buf_wdata;

   // reset release into sclk
   spi_bitsync u_rst_sync (
      .clk      (sclk),
      .rst_n    (avmm_rst_n),
      .data_in  (1'b1),
      .data_out (sclk_rst_n)
   );

   mspi_avmm_csr #(
      .BUF_SIZE (`MSPI_BUF_SIZE)
   ) u_csr (
      .avmm_clk      (avmm_clk),
      .avmm_rst_n    (avmm_rst_n),
      .address       (address),
      .read          (read),
      .write         (write),
      .byteenable    (byteenable),
      .writedata     (writedata),
      .readdata      (readdata),
      .readdatavalid (readdatavalid),
      .spi_inta      (spi_inta),
      .cmd_reg       (cmd_reg),
      .sclk          (sclk),
      .spi_active    (spi_active),
      .tx_buf_raddr  (tx_buf_raddr),
      .tx_buf_rdata  (tx_buf_rdata),
      .rx_buf_we     (rx_buf_we),
      .rx_buf_waddr  (rx_buf_waddr),
      .rx_buf_wdata  (rx_buf_wdata)
   );

   mspi_engine #(
      .BUF_SIZE (`MSPI_BUF_SIZE)
   ) u_engine (
      .sclk         (sclk),
      .rst_n        (sclk_rst_n),
      .cmd_reg      (cmd_reg),
      .tx_buf_raddr (tx_buf_raddr),
      .tx_buf_rdata (tx_buf_rdata),
      .rx_buf_we    (rx_buf_we),
      .rx_buf_waddr (rx_buf_waddr),
      .rx_buf_wdata (rx_buf_wdata),
      .spi_active   (spi_active),
      .spi_sck      (spi_sck),
      .spi_cs_n     (spi_cs_n),
      .spi_mosi     (spi_mosi),
      .spi_miso     (spi_miso)
   );

endmodule

// File: hw/spi_bitsync.sv
// Two-flop synchronizer for a single level signal.
// Used for busy into avmm_clk, go into sclk, and the sclk-domain reset.
`timescale 1ns/100ps

module spi_bitsync (
   input  logic clk,
   input  logic rst_n,     // sync reset, active low
   input  logic data_in,   // async level
   output logic data_out   // level in clk domain
);

   logic meta;  // first stage, may go metastable

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         meta     <= 1'b0;
         data_out <= 1'b0;
      end
      else begin
         meta     <= data_in;
         data_out <= meta;   // second stage settles
      end
   end

endmodule

// File: hw/spi_buf_ram.sv
// Simple dual-port word RAM with separate write and read clocks.
// Read data is registered, one rd_clk cycle after rd_addr.
`timescale 1ns/100ps
`include "mspi_macros.svh"

module spi_buf_ram #(
   parameter int DEPTH = `MSPI_BUF_SIZE,
   parameter int AW    = $clog2(DEPTH)
) (
   input  logic                 wr_clk,
   input  logic                 wr_en,
   input  logic [AW-1:0]        wr_addr,   // word address
   input  mspi_pkg::mspi_word_t wr_data,
   input  logic                 rd_clk,
   input  logic [AW-1:0]        rd_addr,   // word address
   output mspi_pkg::mspi_word_t rd_data
);

   import mspi_pkg::*;

   mspi_word_t mem [DEPTH];  // inferred block ram

   always_ff @(posedge wr_clk) begin
      if (wr_en) mem[wr_addr] <= wr_data;
   end

   always_ff @(posedge rd_clk) begin
      rd_data <= mem[rd_addr];  // registered read port
   end

   // x on the address would corrupt an unknown word
   a_waddr_known : assert property (@(posedge wr_clk) wr_en |-> !$isunknown(wr_addr));

endmodule

// File: src.f
+incdir+hw
hw/mspi_pkg.sv
hw/spi_bitsync.sv
hw/spi_buf_ram.sv
hw/mspi_avmm_csr.sv
hw/mspi_engine.sv
hw/mspi_top.sv
dv/mspi_tb.sv
